//--- hdl/spmv_pkg.sv
package spmv_pkg;

  // engine geometry
  localparam int unsigned NUM_LANES       = 4;
  localparam int unsigned LANE_W          = $clog2(NUM_LANES);
  localparam int unsigned FEAT_DEPTH      = 64;

  // field widths
  localparam int unsigned COL_W           = 6;
  localparam int unsigned ROW_W           = 12;
  localparam int unsigned VAL_W           = 16;
  localparam int unsigned ACC_W           = 40;

  // lane entry fifo, its depth is also the starting credit
  localparam int unsigned LANE_FIFO_DEPTH = 4;
  localparam int unsigned FIFO_PTR_W      = $clog2(LANE_FIFO_DEPTH);
  localparam int unsigned CREDIT_W        = 3;

  // debug monitor
  localparam int unsigned DBG_ROW         = 5;
  localparam int unsigned CNT_W           = 32;

  typedef struct packed {
    logic [ROW_W-1:0] row;
    logic [COL_W-1:0] col;
    logic [VAL_W-1:0] val;
    logic             last;
  } sp_entry_t;

  typedef struct packed {
    logic [COL_W-1:0] addr;
    logic [VAL_W-1:0] data;
  } feat_wr_t;

  typedef struct packed {
    logic [ROW_W-1:0] row;
    logic [ACC_W-1:0] sum;
  } lane_result_t;

  typedef enum logic [1:0] {
    LANE_IDLE,
    LANE_ACCUM,
    LANE_DRAIN,
    LANE_HOLD
  } lane_state_e;

  typedef struct packed {
    logic                 in_seen;
    logic                 out_seen;
    logic                 stall_seen;
    logic [NUM_LANES-1:0] lane_seen;
  } dbg_status_t;

endpackage

//--- hdl/spmv_dispatch.sv
`timescale 1ns/1ns

module spmv_dispatch (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             in_vld_i,
  input  spmv_pkg::sp_entry_t              in_data_i,
  input  logic [spmv_pkg::NUM_LANES-1:0]   lane_credit_i,
  output logic                             in_rdy_o,
  output logic [spmv_pkg::NUM_LANES-1:0]   lane_push_o,
  output spmv_pkg::sp_entry_t              lane_entry_o
);

  logic [spmv_pkg::CREDIT_W-1:0] credit_q [spmv_pkg::NUM_LANES];
  logic [spmv_pkg::LANE_W-1:0]   ptr_q;
  logic                          push;

  // a lane with credit has a free fifo slot, so the entry goes straight in
  assign in_rdy_o     = (credit_q[ptr_q] != '0);
  assign push         = in_vld_i & in_rdy_o;
  assign lane_entry_o = in_data_i;

  always_comb begin
    lane_push_o        = '0;
    lane_push_o[ptr_q] = push;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < spmv_pkg::NUM_LANES; i++) begin
        credit_q[i] <= spmv_pkg::CREDIT_W'(spmv_pkg::LANE_FIFO_DEPTH);
      end
    end else begin
      // credit back on every lane pop, one spent on every push
      for (int i = 0; i < spmv_pkg::NUM_LANES; i++) begin
        credit_q[i] <= credit_q[i]
                     + spmv_pkg::CREDIT_W'(lane_credit_i[i])
                     - spmv_pkg::CREDIT_W'(lane_push_o[i]);
      end
    end
  end

  // whole rows go to one lane, move on after the last entry
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ptr_q <= '0;
    end else if (push && in_data_i.last) begin
      if (ptr_q == spmv_pkg::LANE_W'(spmv_pkg::NUM_LANES - 1)) begin
        ptr_q <= '0;
      end else begin
        ptr_q <= ptr_q + 1'b1;
      end
    end
  end

  for (genvar g = 0; g < spmv_pkg::NUM_LANES; g++) begin : g_credit_chk
    // lanes must never hand back more credit than they were given
    a_credit_bound: assert property (
      @(posedge clk) disable iff (!rst_n)
      credit_q[g] <= spmv_pkg::CREDIT_W'(spmv_pkg::LANE_FIFO_DEPTH)
    ) else $error("lane %0d credit above fifo depth", g);
  end

endmodule

//--- hdl/sppe_lane.sv
`timescale 1ns/1ns

module sppe_lane (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   push_i,
  input  spmv_pkg::sp_entry_t    entry_i,
  input  logic                   feat_wr_en_i,
  input  spmv_pkg::feat_wr_t     feat_wr_i,
  input  logic                   take_i,
  output logic                   credit_o,
  output logic                   res_vld_o,
  output spmv_pkg::lane_result_t res_o,
  output logic                   busy_o
);

  spmv_pkg::sp_entry_t             fifo_mem [spmv_pkg::LANE_FIFO_DEPTH];
  logic [spmv_pkg::FIFO_PTR_W-1:0] wr_ptr_q;
  logic [spmv_pkg::FIFO_PTR_W-1:0] rd_ptr_q;
  logic [spmv_pkg::CREDIT_W-1:0]   fifo_cnt_q;
  logic                            fifo_empty;
  logic                            fifo_full;
  spmv_pkg::sp_entry_t             head;
  logic                            pop;

  logic [spmv_pkg::VAL_W-1:0]      feat_mem [spmv_pkg::FEAT_DEPTH];
  logic [spmv_pkg::VAL_W-1:0]      feat_q;

  logic                            s1_vld_q;
  logic                            s1_last_q;
  logic [spmv_pkg::VAL_W-1:0]      s1_val_q;
  logic [spmv_pkg::ROW_W-1:0]      s1_row_q;

  logic signed [2*spmv_pkg::VAL_W-1:0] prod;
  logic signed [spmv_pkg::ACC_W-1:0]   prod_ext;
  logic [spmv_pkg::ACC_W-1:0]          acc_q;
  logic [spmv_pkg::ROW_W-1:0]          row_q;

  spmv_pkg::lane_state_e state_q;
  spmv_pkg::lane_state_e state_d;

  assign fifo_empty = (fifo_cnt_q == '0);
  assign fifo_full  = (fifo_cnt_q == spmv_pkg::CREDIT_W'(spmv_pkg::LANE_FIFO_DEPTH));
  assign head       = fifo_mem[rd_ptr_q];

  // the next row stays queued until the current sum has been taken
  assign pop = !fifo_empty
             && (state_q == spmv_pkg::LANE_IDLE || state_q == spmv_pkg::LANE_ACCUM);
  assign credit_o = pop;

  always_ff @(posedge clk) begin
    if (push_i) begin
      fifo_mem[wr_ptr_q] <= entry_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      fifo_cnt_q <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      fifo_cnt_q <= fifo_cnt_q + spmv_pkg::CREDIT_W'(push_i) - spmv_pkg::CREDIT_W'(pop);
    end
  end

  // feature copy, registered read at pop time
  always_ff @(posedge clk) begin
    if (feat_wr_en_i) begin
      feat_mem[feat_wr_i.addr] <= feat_wr_i.data;
    end
    if (pop) begin
      feat_q   <= feat_mem[head.col];
      s1_val_q <= head.val;
      s1_row_q <= head.row;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_vld_q  <= 1'b0;
      s1_last_q <= 1'b0;
    end else begin
      s1_vld_q  <= pop;
      s1_last_q <= pop & head.last;
    end
  end

  assign prod     = $signed(s1_val_q) * $signed(feat_q);
  assign prod_ext = prod;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_q <= '0;
    end else if (state_q == spmv_pkg::LANE_HOLD && take_i) begin
      acc_q <= '0;
    end else if (s1_vld_q) begin
      acc_q <= acc_q + prod_ext;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_vld_q) begin
      row_q <= s1_row_q;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      spmv_pkg::LANE_IDLE: begin
        if (pop) begin
          state_d = head.last ? spmv_pkg::LANE_DRAIN : spmv_pkg::LANE_ACCUM;
        end
      end
      spmv_pkg::LANE_ACCUM: begin
        if (pop && head.last) begin
          state_d = spmv_pkg::LANE_DRAIN;
        end
      end
      // last product lands in the accumulator this cycle
      spmv_pkg::LANE_DRAIN: begin
        if (s1_vld_q && s1_last_q) begin
          state_d = spmv_pkg::LANE_HOLD;
        end
      end
      spmv_pkg::LANE_HOLD: begin
        if (take_i) begin
          state_d = spmv_pkg::LANE_IDLE;
        end
      end
      default: state_d = spmv_pkg::LANE_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= spmv_pkg::LANE_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign res_vld_o = (state_q == spmv_pkg::LANE_HOLD);
  assign res_o     = '{row: row_q, sum: acc_q};
  assign busy_o    = (state_q != spmv_pkg::LANE_IDLE);

  // dispatcher credit must keep pushes away from a full fifo
  a_no_push_full: assert property (
    @(posedge clk) disable iff (!rst_n)
    push_i |-> !fifo_full
  ) else $error("push into full lane fifo");

endmodule

//--- hdl/spmv_collect.sv
`timescale 1ns/1ns

module spmv_collect (
  input  logic                                                clk,
  input  logic                                                rst_n,
  input  logic [spmv_pkg::NUM_LANES-1:0]                      lane_res_vld_i,
  input  spmv_pkg::lane_result_t [spmv_pkg::NUM_LANES-1:0]    lane_res_i,
  input  logic                                                out_rdy_i,
  output logic [spmv_pkg::NUM_LANES-1:0]                      lane_take_o,
  output logic                                                out_vld_o,
  output spmv_pkg::lane_result_t                              out_data_o
);

  logic [spmv_pkg::LANE_W-1:0] ptr_q;
  logic                        xfer;

  // same order as dispatch, so rows leave in input order
  assign out_vld_o  = lane_res_vld_i[ptr_q];
  assign out_data_o = lane_res_i[ptr_q];
  assign xfer       = out_vld_o & out_rdy_i;

  always_comb begin
    lane_take_o        = '0;
    lane_take_o[ptr_q] = xfer;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ptr_q <= '0;
    end else if (xfer) begin
      if (ptr_q == spmv_pkg::LANE_W'(spmv_pkg::NUM_LANES - 1)) begin
        ptr_q <= '0;
      end else begin
        ptr_q <= ptr_q + 1'b1;
      end
    end
  end

  // the held lane must keep its result steady under back-pressure
  a_out_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    (out_vld_o && !out_rdy_i) |=> (out_vld_o && $stable(out_data_o))
  ) else $error("output changed while stalled");

endmodule

//--- hdl/spmv_debugger.sv
`timescale 1ns/1ns

module spmv_debugger (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           in_vld_i,
  input  logic                           in_rdy_i,
  input  logic                           out_vld_i,
  input  logic                           out_rdy_i,
  input  spmv_pkg::lane_result_t         out_data_i,
  input  logic [spmv_pkg::NUM_LANES-1:0] lane_busy_i,
  output spmv_pkg::dbg_status_t          status_o,
  output logic [spmv_pkg::CNT_W-1:0]     count_o,
  output logic [spmv_pkg::ACC_W-1:0]     capture_o
);

  spmv_pkg::dbg_status_t         status_q;
  logic [spmv_pkg::CNT_W-1:0]    count_q;
  logic [spmv_pkg::ACC_W-1:0]    capture_q;
  logic                          in_xfer;
  logic                          out_xfer;
  logic                          dbg_hit;

  assign in_xfer  = in_vld_i & in_rdy_i;
  assign out_xfer = out_vld_i & out_rdy_i;
  assign dbg_hit  = out_xfer && (out_data_i.row == spmv_pkg::ROW_W'(spmv_pkg::DBG_ROW));

  // sticky bits, only reset clears them
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      status_q <= '0;
    end else begin
      status_q.in_seen    <= status_q.in_seen | in_xfer;
      status_q.out_seen   <= status_q.out_seen | out_xfer;
      status_q.stall_seen <= status_q.stall_seen | (out_vld_i & ~out_rdy_i);
      status_q.lane_seen  <= status_q.lane_seen | lane_busy_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count_q   <= '0;
      capture_q <= '0;
    end else begin
      if (out_xfer) begin
        count_q <= count_q + 1'b1;
      end
      // keeps the latest sum seen for the watched row
      if (dbg_hit) begin
        capture_q <= out_data_i.sum;
      end
    end
  end

  assign status_o  = status_q;
  assign count_o   = count_q;
  assign capture_o = capture_q;

endmodule

//--- hdl/spmv_top.sv
`timescale 1ns/1ns

module spmv_top (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           in_vld_i,
  input  spmv_pkg::sp_entry_t            in_data_i,
  input  logic                           feat_wr_en_i,
  input  spmv_pkg::feat_wr_t             feat_wr_i,
  input  logic                           out_rdy_i,
  output logic                           in_rdy_o,
  output logic                           out_vld_o,
  output spmv_pkg::lane_result_t         out_data_o,
  output spmv_pkg::dbg_status_t          dbg_status_o,
  output logic [spmv_pkg::CNT_W-1:0]     dbg_count_o,
  output logic [spmv_pkg::ACC_W-1:0]     dbg_capture_o
);

  logic [spmv_pkg::NUM_LANES-1:0]                   lane_push;
  spmv_pkg::sp_entry_t                              lane_entry;
  logic [spmv_pkg::NUM_LANES-1:0]                   lane_credit;
  logic [spmv_pkg::NUM_LANES-1:0]                   lane_res_vld;
  spmv_pkg::lane_result_t [spmv_pkg::NUM_LANES-1:0] lane_res;
  logic [spmv_pkg::NUM_LANES-1:0]                   lane_take;
  logic [spmv_pkg::NUM_LANES-1:0]                   lane_busy;

  spmv_dispatch u_dispatch (
    .clk           (clk),
    .rst_n         (rst_n),
    .in_vld_i      (in_vld_i),
    .in_data_i     (in_data_i),
    .lane_credit_i (lane_credit),
    .in_rdy_o      (in_rdy_o),
    .lane_push_o   (lane_push),
    .lane_entry_o  (lane_entry)
  );

  // features are broadcast so every lane holds a full copy
  for (genvar g = 0; g < spmv_pkg::NUM_LANES; g++) begin : g_lane
    sppe_lane u_lane (
      .clk          (clk),
      .rst_n        (rst_n),
      .push_i       (lane_push[g]),
      .entry_i      (lane_entry),
      .feat_wr_en_i (feat_wr_en_i),
      .feat_wr_i    (feat_wr_i),
      .take_i       (lane_take[g]),
      .credit_o     (lane_credit[g]),
      .res_vld_o    (lane_res_vld[g]),
      .res_o        (lane_res[g]),
      .busy_o       (lane_busy[g])
    );
  end

  spmv_collect u_collect (
    .clk            (clk),
    .rst_n          (rst_n),
    .lane_res_vld_i (lane_res_vld),
    .lane_res_i     (lane_res),
    .out_rdy_i      (out_rdy_i),
    .lane_take_o    (lane_take),
    .out_vld_o      (out_vld_o),
    .out_data_o     (out_data_o)
  );

  spmv_debugger u_debugger (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_vld_i    (in_vld_i),
    .in_rdy_i    (in_rdy_o),
    .out_vld_i   (out_vld_o),
    .out_rdy_i   (out_rdy_i),
    .out_data_i  (out_data_o),
    .lane_busy_i (lane_busy),
    .status_o    (dbg_status_o),
    .count_o     (dbg_count_o),
    .capture_o   (dbg_capture_o)
  );

endmodule

//--- verification/tb_spmv_top.sv
`timescale 1ns/1ns

module tb_spmv_top;

  localparam int unsigned SEED         = 22;
  localparam int unsigned SHORT_ROWS   = 6;
  localparam int unsigned LOAD_ROWS    = 40;
  localparam int unsigned BP_ROWS      = 40;
  localparam int unsigned TOTAL_ROWS   = SHORT_ROWS + LOAD_ROWS + BP_ROWS;
  localparam int unsigned WATCHDOG_CYC = 200 * TOTAL_ROWS;

  logic                              clk;
  logic                              rst_n;
  logic                              in_vld_i;
  spmv_pkg::sp_entry_t               in_data_i;
  logic                              feat_wr_en_i;
  spmv_pkg::feat_wr_t                feat_wr_i;
  logic                              out_rdy_i;
  logic                              in_rdy_o;
  logic                              out_vld_o;
  spmv_pkg::lane_result_t            out_data_o;
  spmv_pkg::dbg_status_t             dbg_status_o;
  logic [spmv_pkg::CNT_W-1:0]        dbg_count_o;
  logic [spmv_pkg::ACC_W-1:0]        dbg_capture_o;

  logic signed [spmv_pkg::VAL_W-1:0] feat_copy [spmv_pkg::FEAT_DEPTH];
  logic [spmv_pkg::COL_W-1:0]        row_col [8];
  logic signed [spmv_pkg::VAL_W-1:0] row_val [8];
  spmv_pkg::lane_result_t            exp_q [$];
  spmv_pkg::lane_result_t            exp_head;
  logic [spmv_pkg::ACC_W-1:0]        dbg_expect;
  logic [31:0]                       stim_state;
  logic [31:0]                       rdy_state;
  logic                              rdy_random;
  int                                err_cnt;
  int                                check_cnt;
  int                                rows_sent;
  int                                results_seen;
  int                                errs_before;

  spmv_top u_spmv_top (
    .clk           (clk),
    .rst_n         (rst_n),
    .in_vld_i      (in_vld_i),
    .in_data_i     (in_data_i),
    .feat_wr_en_i  (feat_wr_en_i),
    .feat_wr_i     (feat_wr_i),
    .out_rdy_i     (out_rdy_i),
    .in_rdy_o      (in_rdy_o),
    .out_vld_o     (out_vld_o),
    .out_data_o    (out_data_o),
    .dbg_status_o  (dbg_status_o),
    .dbg_count_o   (dbg_count_o),
    .dbg_capture_o (dbg_capture_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_stim();
    stim_state = xorshift32(stim_state);
    return stim_state;
  endfunction

  // dot product of the stored row with the local feature copy
  function automatic logic signed [spmv_pkg::ACC_W-1:0] row_sum(input int len);
    logic signed [spmv_pkg::ACC_W-1:0] acc;
    acc = '0;
    for (int i = 0; i < len; i++) begin
      acc = acc + row_val[i] * feat_copy[row_col[i]];
    end
    return acc;
  endfunction

  task automatic load_features();
    logic [31:0] r;
    for (int a = 0; a < spmv_pkg::FEAT_DEPTH; a++) begin
      r = next_stim();
      feat_copy[a]   = r[15:0];
      feat_wr_en_i   = 1'b1;
      feat_wr_i.addr = spmv_pkg::COL_W'(a);
      feat_wr_i.data = r[15:0];
      @(posedge clk);
      #1;
    end
    feat_wr_en_i = 1'b0;
  endtask

  // called 1 ns after an edge, returns 1 ns after the accepting edge
  task automatic send_entry(input spmv_pkg::sp_entry_t e);
    in_vld_i  = 1'b1;
    in_data_i = e;
    // in_rdy_o only moves at the edge, so its value now holds for the next edge
    while (!in_rdy_o) begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    #1;
    in_vld_i = 1'b0;
  endtask

  task automatic send_row(input logic [spmv_pkg::ROW_W-1:0] id, input int max_len);
    logic [31:0]            r;
    int                     len;
    spmv_pkg::lane_result_t exp;
    spmv_pkg::sp_entry_t    e;
    r   = next_stim();
    len = 1 + int'(r % max_len);
    for (int i = 0; i < len; i++) begin
      r          = next_stim();
      row_col[i] = r[5:0];
      row_val[i] = r[31:16];
    end
    exp.row = id;
    exp.sum = row_sum(len);
    exp_q.push_back(exp);
    if (id == spmv_pkg::ROW_W'(spmv_pkg::DBG_ROW)) begin
      dbg_expect = exp.sum;
    end
    for (int i = 0; i < len; i++) begin
      e.row  = id;
      e.col  = row_col[i];
      e.val  = row_val[i];
      e.last = (i == len - 1);
      send_entry(e);
    end
    rows_sent++;
  endtask

  task automatic drain();
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (4) @(posedge clk);
    #1;
    check_cnt++;
    if (out_vld_o) begin
      $display("ERROR t=%0t: result row %0d present after all rows were returned",
               $time, out_data_o.row);
      err_cnt++;
    end
  endtask

  task automatic report_test(input string name, input int errs_at_start);
    if (err_cnt == errs_at_start) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, err_cnt - errs_at_start);
    end
  endtask

  // compare every output handshake with the oldest expected row
  // mid-cycle values are the ones the next rising edge takes
  always @(negedge clk) begin
    if (rst_n && out_vld_o && out_rdy_i) begin
      results_seen++;
      check_cnt++;
      if (exp_q.size() == 0) begin
        $display("ERROR t=%0t: row %0d returned with no row outstanding", $time, out_data_o.row);
        err_cnt++;
      end else begin
        exp_head = exp_q.pop_front();
        if (out_data_o.row != exp_head.row || out_data_o.sum != exp_head.sum) begin
          $display("ERROR t=%0t: got row %0d sum %0d, expected row %0d sum %0d", $time,
                   out_data_o.row, $signed(out_data_o.sum), exp_head.row,
                   $signed(exp_head.sum));
          err_cnt++;
        end
      end
    end
  end

  // random sink stalls, enable sampled at the edge
  always @(posedge clk) begin
    if (rdy_random) begin
      #1;
      rdy_state = xorshift32(rdy_state);
      out_rdy_i = rdy_state[0];
    end
  end

  initial begin
    repeat (WATCHDOG_CYC) @(posedge clk);
    $display("run timed out after %0d cycles, %0d rows still outstanding",
             WATCHDOG_CYC, exp_q.size());
    $display("Simulation failed");
    $finish;
  end

  initial begin
    rst_n        = 1'b0;
    in_vld_i     = 1'b0;
    in_data_i    = '0;
    feat_wr_en_i = 1'b0;
    feat_wr_i    = '0;
    out_rdy_i    = 1'b1;
    rdy_random   = 1'b0;
    stim_state   = SEED;
    rdy_state    = SEED ^ 32'h5bd1e995;
    dbg_expect   = '0;
    err_cnt      = 0;
    check_cnt    = 0;
    rows_sent    = 0;
    results_seen = 0;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;

    errs_before = err_cnt;
    @(posedge clk);
    #1;
    check_cnt++;
    if (out_vld_o !== 1'b0 || in_rdy_o !== 1'b1) begin
      $display("ERROR t=%0t: after reset out_vld_o=%b in_rdy_o=%b", $time, out_vld_o, in_rdy_o);
      err_cnt++;
    end
    check_cnt++;
    if (dbg_status_o !== '0 || dbg_count_o !== '0 || dbg_capture_o !== '0) begin
      $display("ERROR t=%0t: debug outputs not zero after reset", $time);
      err_cnt++;
    end
    report_test("reset state", errs_before);

    errs_before = err_cnt;
    load_features();
    for (int i = 0; i < SHORT_ROWS; i++) begin
      send_row(spmv_pkg::ROW_W'(i), 3);
    end
    drain();
    report_test("single rows in order", errs_before);

    errs_before = err_cnt;
    for (int i = 0; i < LOAD_ROWS; i++) begin
      send_row(spmv_pkg::ROW_W'(i), 8);
    end
    drain();
    check_cnt++;
    if (dbg_status_o.lane_seen != '1) begin
      $display("ERROR t=%0t: lane_seen is %b, every lane should be set",
               $time, dbg_status_o.lane_seen);
      err_cnt++;
    end
    report_test("all lanes under load", errs_before);

    // new features while idle, then rows under a stalling sink
    errs_before = err_cnt;
    load_features();
    rdy_random = 1'b1;
    for (int i = 0; i < BP_ROWS; i++) begin
      send_row(spmv_pkg::ROW_W'(i), 8);
    end
    drain();
    rdy_random = 1'b0;
    @(posedge clk);
    #1;
    out_rdy_i = 1'b1;
    check_cnt++;
    if (!dbg_status_o.stall_seen) begin
      $display("ERROR t=%0t: stall_seen not set under back-pressure", $time);
      err_cnt++;
    end
    report_test("back-pressure", errs_before);

    errs_before = err_cnt;
    check_cnt++;
    if (dbg_count_o != spmv_pkg::CNT_W'(rows_sent) || results_seen != rows_sent) begin
      $display("ERROR t=%0t: dbg_count_o=%0d results=%0d rows sent=%0d",
               $time, dbg_count_o, results_seen, rows_sent);
      err_cnt++;
    end
    check_cnt++;
    if (dbg_capture_o != dbg_expect) begin
      $display("ERROR t=%0t: dbg_capture_o=%0d, expected %0d",
               $time, $signed(dbg_capture_o), $signed(dbg_expect));
      err_cnt++;
    end
    check_cnt++;
    if (!dbg_status_o.in_seen || !dbg_status_o.out_seen) begin
      $display("ERROR t=%0t: in_seen=%b out_seen=%b", $time,
               dbg_status_o.in_seen, dbg_status_o.out_seen);
      err_cnt++;
    end
    report_test("debug counters", errs_before);

    $display("rows=%0d results=%0d checks=%0d errors=%0d",
             rows_sent, results_seen, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- verilog.f
hdl/spmv_pkg.sv
hdl/spmv_dispatch.sv
hdl/sppe_lane.sv
hdl/spmv_collect.sv
hdl/spmv_debugger.sv
hdl/spmv_top.sv
verification/tb_spmv_top.sv

//--- Bender.yml
package:
  name: spmv

sources:
  - files:
      - hdl/spmv_pkg.sv
      - hdl/spmv_dispatch.sv
      - hdl/sppe_lane.sv
      - hdl/spmv_collect.sv
      - hdl/spmv_debugger.sv
      - hdl/spmv_top.sv
  - target: test
    files:
      - verification/tb_spmv_top.sv
